// ==== verilog/mcu_pkg.sv ====
// system bus widths and memory map; all addresses are byte addresses
// every region must stay inside a 4 KiB window except the SRAM base at 0

package mcu_pkg;

  // bus widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned SEL_WIDTH = 4;

  // sram depth in 32-bit words
  localparam int unsigned RAM_WORDS = 1024;

  // region bases
  localparam logic [31:0] RAM_START = 32'h0000_0000;
  localparam logic [31:0] AO_PERIPH_START = 32'h2000_0000;
  localparam logic [31:0] DMA_START = 32'h2000_1000;

  // span of one peripheral region in bytes
  localparam logic [31:0] REGION_SIZE = 32'h0000_1000;

  // bus owner
  typedef enum logic {
    MASTER_HOST,
    MASTER_DMA
  } bus_master_e;

endpackage

// ==== verilog/periph_pkg.sv ====
// register map of the always-on peripheral and the dma
// offsets are byte offsets inside a 4 KiB region, word aligned

package periph_pkg;

  localparam int unsigned GPIO_WIDTH = 8;

  // always-on peripheral
  localparam logic [11:0] GPIO_OUT_OFS = 12'h000;
  localparam logic [11:0] GPIO_OE_OFS = 12'h004;
  localparam logic [11:0] GPIO_IN_OFS = 12'h008;
  localparam logic [11:0] EXIT_VALUE_OFS = 12'h00C;
  localparam logic [11:0] EXIT_VALID_OFS = 12'h010;

  // dma; size counts words, ctrl bit 0 start, bit 1 done
  localparam logic [11:0] DMA_SRC_OFS = 12'h000;
  localparam logic [11:0] DMA_DST_OFS = 12'h004;
  localparam logic [11:0] DMA_SIZE_OFS = 12'h008;
  localparam logic [11:0] DMA_CTRL_OFS = 12'h00C;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_READ,
    DMA_WRITE,
    DMA_DONE
  } dma_state_e;

endpackage

// ==== verilog/system_bus.sv ====
// wishbone classic arbiter for host and dma plus address decoder
// owner keeps the bus until it drops cyc; one free cycle between owners
// unmapped addresses ack after one cycle with zero read data
`timescale 1ns/1ps

module system_bus (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        h_cyc_i,
  input  logic        h_stb_i,
  input  logic        h_we_i,
  input  logic [31:0] h_adr_i,
  input  logic [31:0] h_dat_i,
  input  logic [3:0]  h_sel_i,
  output logic [31:0] h_dat_o,
  output logic        h_ack_o,
  input  logic        d_cyc_i,
  input  logic        d_stb_i,
  input  logic        d_we_i,
  input  logic [31:0] d_adr_i,
  input  logic [31:0] d_dat_i,
  input  logic [3:0]  d_sel_i,
  output logic [31:0] d_dat_o,
  output logic        d_ack_o,
  output logic        s_we_o,
  output logic [31:0] s_adr_o,
  output logic [31:0] s_dat_o,
  output logic [3:0]  s_sel_o,
  output logic        ram_stb_o,
  output logic        ao_stb_o,
  output logic        dma_stb_o,
  input  logic [31:0] ram_dat_i,
  input  logic        ram_ack_i,
  input  logic [31:0] ao_dat_i,
  input  logic        ao_ack_i,
  input  logic [31:0] dma_dat_i,
  input  logic        dma_ack_i
);

  mcu_pkg::bus_master_e owner_q;
  mcu_pkg::bus_master_e last_q;
  mcu_pkg::bus_master_e grant_d;
  logic        busy_q;
  logic        own_host;
  logic        own_cyc;
  logic        req;
  logic        sel_ram;
  logic        sel_ao;
  logic        sel_dma;
  logic        sel_none;
  logic        none_ack_q;
  logic        bus_ack;
  logic [31:0] bus_dat;

  function automatic logic in_region(input logic [31:0] adr, input logic [31:0] base,
                                     input logic [31:0] size);
    return (adr - base) < size;
  endfunction

  // round robin: on a tie the master not served last wins
  always_comb begin
    if (h_cyc_i && d_cyc_i) begin
      grant_d = (last_q == mcu_pkg::MASTER_HOST) ? mcu_pkg::MASTER_DMA : mcu_pkg::MASTER_HOST;
    end else if (h_cyc_i) begin
      grant_d = mcu_pkg::MASTER_HOST;
    end else begin
      grant_d = mcu_pkg::MASTER_DMA;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      owner_q <= mcu_pkg::MASTER_HOST;
      last_q  <= mcu_pkg::MASTER_DMA;
    end else if (busy_q) begin
      if (!own_cyc) begin
        busy_q <= 1'b0;
        last_q <= owner_q;
      end
    end else if (h_cyc_i || d_cyc_i) begin
      busy_q  <= 1'b1;
      owner_q <= grant_d;
    end
  end

  assign own_host = (owner_q == mcu_pkg::MASTER_HOST);
  assign own_cyc  = own_host ? h_cyc_i : d_cyc_i;
  assign req      = busy_q & own_cyc & (own_host ? h_stb_i : d_stb_i);

  assign s_we_o  = own_host ? h_we_i : d_we_i;
  assign s_adr_o = own_host ? h_adr_i : d_adr_i;
  assign s_dat_o = own_host ? h_dat_i : d_dat_i;
  assign s_sel_o = own_host ? h_sel_i : d_sel_i;

  assign sel_ram  = in_region(s_adr_o, mcu_pkg::RAM_START, mcu_pkg::RAM_WORDS * 4);
  assign sel_ao   = in_region(s_adr_o, mcu_pkg::AO_PERIPH_START, mcu_pkg::REGION_SIZE);
  assign sel_dma  = in_region(s_adr_o, mcu_pkg::DMA_START, mcu_pkg::REGION_SIZE);
  assign sel_none = ~(sel_ram | sel_ao | sel_dma);

  assign ram_stb_o = req & sel_ram;
  assign ao_stb_o  = req & sel_ao;
  assign dma_stb_o = req & sel_dma;

  // responder for holes in the map
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      none_ack_q <= 1'b0;
    end else begin
      none_ack_q <= req & sel_none & ~none_ack_q;
    end
  end

  assign bus_ack = (sel_ram & ram_ack_i) | (sel_ao & ao_ack_i) | (sel_dma & dma_ack_i) |
                   (sel_none & none_ack_q);
  assign bus_dat = sel_ram ? ram_dat_i : sel_ao ? ao_dat_i : sel_dma ? dma_dat_i : 32'h0;

  assign h_ack_o = busy_q & own_host & bus_ack;
  assign d_ack_o = busy_q & ~own_host & bus_ack;
  assign h_dat_o = bus_dat;
  assign d_dat_o = bus_dat;

endmodule

// ==== verilog/ram_bank.sv ====
// single-port sram slave, word addressed, byte write enables
// contents are undefined after power up
`timescale 1ns/1ps

module ram_bank (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 stb_i,
  input  logic                                 we_i,
  input  logic [$clog2(mcu_pkg::RAM_WORDS)-1:0] adr_i,
  input  logic [31:0]                          dat_i,
  input  logic [3:0]                           sel_i,
  output logic [31:0]                          dat_o,
  output logic                                 ack_o
);

  logic [31:0] mem [mcu_pkg::RAM_WORDS];

  always_ff @(posedge clk_i) begin
    if (stb_i && !ack_o) begin
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (sel_i[b]) begin
            mem[adr_i][b*8 +: 8] <= dat_i[b*8 +: 8];
          end
        end
      end
      dat_o <= mem[adr_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= stb_i & ~ack_o;
    end
  end

endmodule

// ==== verilog/dma_engine.sv ====
// word-copy dma: one read then one write per word, one transfer in flight
// addresses step by 4; size 0 completes at once; start while busy is dropped
`timescale 1ns/1ps

module dma_engine (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        cfg_stb_i,
  input  logic        cfg_we_i,
  input  logic [11:0] cfg_adr_i,
  input  logic [31:0] cfg_dat_i,
  output logic [31:0] cfg_dat_o,
  output logic        cfg_ack_o,
  output logic        m_cyc_o,
  output logic        m_stb_o,
  output logic        m_we_o,
  output logic [31:0] m_adr_o,
  output logic [31:0] m_dat_o,
  output logic [3:0]  m_sel_o,
  input  logic [31:0] m_dat_i,
  input  logic        m_ack_i,
  output logic        dma_done_o
);

  periph_pkg::dma_state_e state_q;
  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [31:0] size_q;
  logic [31:0] cnt_q;
  logic [31:0] buf_q;
  logic        cyc_q;
  logic        busy;
  logic        cfg_wr;
  logic        ctrl_wr;

  assign cfg_wr  = cfg_stb_i & cfg_we_i & ~cfg_ack_o;
  assign ctrl_wr = cfg_wr & (cfg_adr_i == periph_pkg::DMA_CTRL_OFS);
  assign busy    = (state_q == periph_pkg::DMA_READ) || (state_q == periph_pkg::DMA_WRITE);

  // configuration registers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_ack_o <= 1'b0;
      src_q     <= '0;
      dst_q     <= '0;
      size_q    <= '0;
    end else begin
      cfg_ack_o <= cfg_stb_i & ~cfg_ack_o;
      if (cfg_wr) begin
        case (cfg_adr_i)
          periph_pkg::DMA_SRC_OFS:  src_q <= cfg_dat_i;
          periph_pkg::DMA_DST_OFS:  dst_q <= cfg_dat_i;
          periph_pkg::DMA_SIZE_OFS: size_q <= cfg_dat_i;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_stb_i && !cfg_ack_o) begin
      case (cfg_adr_i)
        periph_pkg::DMA_SRC_OFS:  cfg_dat_o <= src_q;
        periph_pkg::DMA_DST_OFS:  cfg_dat_o <= dst_q;
        periph_pkg::DMA_SIZE_OFS: cfg_dat_o <= size_q;
        periph_pkg::DMA_CTRL_OFS: cfg_dat_o <= {30'h0, dma_done_o, busy};
        default:                  cfg_dat_o <= 32'h0;
      endcase
    end
  end

  // copy fsm; cyc drops for a cycle after every ack so the arbiter can rotate
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= periph_pkg::DMA_IDLE;
      cyc_q   <= 1'b0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        periph_pkg::DMA_IDLE: begin
          if (ctrl_wr && cfg_dat_i[0]) begin
            cnt_q   <= '0;
            state_q <= (size_q == 32'h0) ? periph_pkg::DMA_DONE : periph_pkg::DMA_READ;
          end
        end
        periph_pkg::DMA_READ: begin
          if (m_ack_i) begin
            cyc_q   <= 1'b0;
            state_q <= periph_pkg::DMA_WRITE;
          end else begin
            cyc_q <= 1'b1;
          end
        end
        periph_pkg::DMA_WRITE: begin
          if (m_ack_i) begin
            cyc_q   <= 1'b0;
            cnt_q   <= cnt_q + 32'd1;
            state_q <= (cnt_q + 32'd1 == size_q) ? periph_pkg::DMA_DONE : periph_pkg::DMA_READ;
          end else begin
            cyc_q <= 1'b1;
          end
        end
        default: begin
          if (ctrl_wr && cfg_dat_i[1]) begin
            state_q <= periph_pkg::DMA_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == periph_pkg::DMA_READ && m_ack_i) begin
      buf_q <= m_dat_i;
    end
  end

  assign m_cyc_o    = cyc_q;
  assign m_stb_o    = cyc_q;
  assign m_we_o     = (state_q == periph_pkg::DMA_WRITE);
  assign m_adr_o    = (m_we_o ? dst_q : src_q) + {cnt_q[29:0], 2'b00};
  assign m_dat_o    = buf_q;
  assign m_sel_o    = 4'hF;
  assign dma_done_o = (state_q == periph_pkg::DMA_DONE);

endmodule

// ==== verilog/ao_peripheral.sv ====
// always-on gpio block plus exit registers; gpio_i is asynchronous
// exit valid is sticky until reset; byte selects are ignored
`timescale 1ns/1ps

module ao_peripheral (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              stb_i,
  input  logic                              we_i,
  input  logic [11:0]                       adr_i,
  input  logic [31:0]                       dat_i,
  output logic [31:0]                       dat_o,
  output logic                              ack_o,
  input  logic [periph_pkg::GPIO_WIDTH-1:0] gpio_i,
  output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_o,
  output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_oe_o,
  output logic                              exit_valid_o,
  output logic [31:0]                       exit_value_o
);

  logic [periph_pkg::GPIO_WIDTH-1:0] sync_q1;
  logic [periph_pkg::GPIO_WIDTH-1:0] sync_q2;
  logic                              wr;

  assign wr = stb_i & we_i & ~ack_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_o        <= 1'b0;
      gpio_o       <= '0;
      gpio_oe_o    <= '0;
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
      sync_q1      <= '0;
      sync_q2      <= '0;
    end else begin
      ack_o   <= stb_i & ~ack_o;
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
      if (wr) begin
        case (adr_i)
          periph_pkg::GPIO_OUT_OFS:   gpio_o <= dat_i[periph_pkg::GPIO_WIDTH-1:0];
          periph_pkg::GPIO_OE_OFS:    gpio_oe_o <= dat_i[periph_pkg::GPIO_WIDTH-1:0];
          periph_pkg::EXIT_VALUE_OFS: exit_value_o <= dat_i;
          periph_pkg::EXIT_VALID_OFS: exit_valid_o <= exit_valid_o | dat_i[0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (stb_i && !ack_o) begin
      case (adr_i)
        periph_pkg::GPIO_OUT_OFS:   dat_o <= 32'(gpio_o);
        periph_pkg::GPIO_OE_OFS:    dat_o <= 32'(gpio_oe_o);
        periph_pkg::GPIO_IN_OFS:    dat_o <= 32'(sync_q2);
        periph_pkg::EXIT_VALUE_OFS: dat_o <= exit_value_o;
        periph_pkg::EXIT_VALID_OFS: dat_o <= {31'h0, exit_valid_o};
        default:                    dat_o <= 32'h0;
      endcase
    end
  end

endmodule

// ==== verilog/core_v_mini_mcu.sv ====
// always-on mcu slice: host port and dma share one wishbone bus
// uncontended host access acks two clocks after stb
`timescale 1ns/1ps

module core_v_mini_mcu (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              host_cyc_i,
  input  logic                              host_stb_i,
  input  logic                              host_we_i,
  input  logic [mcu_pkg::ADDR_WIDTH-1:0]    host_adr_i,
  input  logic [mcu_pkg::DATA_WIDTH-1:0]    host_dat_i,
  input  logic [mcu_pkg::SEL_WIDTH-1:0]     host_sel_i,
  output logic [mcu_pkg::DATA_WIDTH-1:0]    host_dat_o,
  output logic                              host_ack_o,
  input  logic [periph_pkg::GPIO_WIDTH-1:0] gpio_i,
  output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_o,
  output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_oe_o,
  output logic                              exit_valid_o,
  output logic [31:0]                       exit_value_o,
  output logic                              dma_done_o
);

  // dma master side
  logic        d_cyc, d_stb, d_we, d_ack;
  logic [31:0] d_adr, d_wdat, d_rdat;
  logic [3:0]  d_sel;

  // shared slave side
  logic        s_we;
  logic [31:0] s_adr, s_dat;
  logic [3:0]  s_sel;
  logic        ram_stb, ao_stb, dma_stb;
  logic        ram_ack, ao_ack, dma_ack;
  logic [31:0] ram_dat, ao_dat, dma_dat;

  system_bus system_bus_i (
    .clk_i, .rst_n_i,
    .h_cyc_i(host_cyc_i), .h_stb_i(host_stb_i), .h_we_i(host_we_i), .h_adr_i(host_adr_i),
    .h_dat_i(host_dat_i), .h_sel_i(host_sel_i), .h_dat_o(host_dat_o), .h_ack_o(host_ack_o),
    .d_cyc_i(d_cyc), .d_stb_i(d_stb), .d_we_i(d_we), .d_adr_i(d_adr),
    .d_dat_i(d_wdat), .d_sel_i(d_sel), .d_dat_o(d_rdat), .d_ack_o(d_ack),
    .s_we_o(s_we), .s_adr_o(s_adr), .s_dat_o(s_dat), .s_sel_o(s_sel),
    .ram_stb_o(ram_stb), .ao_stb_o(ao_stb), .dma_stb_o(dma_stb),
    .ram_dat_i(ram_dat), .ram_ack_i(ram_ack), .ao_dat_i(ao_dat), .ao_ack_i(ao_ack),
    .dma_dat_i(dma_dat), .dma_ack_i(dma_ack)
  );

  ram_bank ram_bank_i (
    .clk_i, .rst_n_i, .stb_i(ram_stb), .we_i(s_we),
    .adr_i(s_adr[$clog2(mcu_pkg::RAM_WORDS)+1:2]), .dat_i(s_dat), .sel_i(s_sel),
    .dat_o(ram_dat), .ack_o(ram_ack)
  );

  ao_peripheral ao_peripheral_i (
    .clk_i, .rst_n_i, .stb_i(ao_stb), .we_i(s_we), .adr_i(s_adr[11:0]), .dat_i(s_dat),
    .dat_o(ao_dat), .ack_o(ao_ack), .gpio_i, .gpio_o, .gpio_oe_o, .exit_valid_o, .exit_value_o
  );

  dma_engine dma_engine_i (
    .clk_i, .rst_n_i,
    .cfg_stb_i(dma_stb), .cfg_we_i(s_we), .cfg_adr_i(s_adr[11:0]), .cfg_dat_i(s_dat),
    .cfg_dat_o(dma_dat), .cfg_ack_o(dma_ack),
    .m_cyc_o(d_cyc), .m_stb_o(d_stb), .m_we_o(d_we), .m_adr_o(d_adr), .m_dat_o(d_wdat),
    .m_sel_o(d_sel), .m_dat_i(d_rdat), .m_ack_i(d_ack), .dma_done_o
  );

endmodule

// ==== verification/tb_core_v_mini_mcu.sv ====
// directed testbench for the mcu slice; host drives inputs on the falling edge
// ram regions: 0x000-0x4ff host tests, 0x600 contention, 0x800 dma source, 0xa00/0xc00 copies
`timescale 1ns/1ps

module tb_core_v_mini_mcu;

  // two 64-word copies take about 1500 cycles in total
  localparam int MAX_CYCLES = 20000;
  localparam int COPY_WORDS = 64;
  localparam logic [31:0] SRC_BASE = 32'h0000_0800;
  localparam logic [31:0] DST_BASE = 32'h0000_0C00;
  localparam logic [31:0] DST2_BASE = 32'h0000_0A00;
  localparam logic [31:0] HOST_BASE = 32'h0000_0600;
  localparam logic [31:0] UNMAPPED = 32'h4000_0000;

  logic        clk_i;
  logic        rst_n_i;
  logic        host_cyc_i;
  logic        host_stb_i;
  logic        host_we_i;
  logic [31:0] host_adr_i;
  logic [31:0] host_dat_i;
  logic [3:0]  host_sel_i;
  logic [31:0] host_dat_o;
  logic        host_ack_o;
  logic [7:0]  gpio_i;
  logic [7:0]  gpio_o;
  logic [7:0]  gpio_oe_o;
  logic        exit_valid_o;
  logic [31:0] exit_value_o;
  logic        dma_done_o;

  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          cycles = 0;
  int          last_latency;
  logic [31:0] rng_state = 32'd21602;
  logic [31:0] src_words [COPY_WORDS];

  core_v_mini_mcu uut (
    .clk_i, .rst_n_i, .host_cyc_i, .host_stb_i, .host_we_i, .host_adr_i, .host_dat_i,
    .host_sel_i, .host_dat_o, .host_ack_o, .gpio_i, .gpio_o, .gpio_oe_o, .exit_valid_o,
    .exit_value_o, .dma_done_o
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run passed %0d cycles, a bus access or dma copy never ended", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  // xorshift32
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] ao_reg(input logic [11:0] ofs);
    return {mcu_pkg::AO_PERIPH_START[31:12], ofs};
  endfunction

  function automatic logic [31:0] dma_reg(input logic [11:0] ofs);
    return {mcu_pkg::DMA_START[31:12], ofs};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("** Error at %0d ns: %s expected 0x%08h, actual 0x%08h", $time, name, exp, act);
      errors++;
    end
  endtask

  // one host transfer; edges counts rising edges from stb to ack
  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                            input logic [3:0] sel, output logic [31:0] rdat);
    int edges;
    edges = 0;
    @(negedge clk_i);
    host_cyc_i = 1'b1;
    host_stb_i = 1'b1;
    host_we_i  = we;
    host_adr_i = adr;
    host_dat_i = wdat;
    host_sel_i = sel;
    do begin
      @(negedge clk_i);
      edges++;
    end while (!host_ack_o);
    rdat = host_dat_o;
    host_cyc_i = 1'b0;
    host_stb_i = 1'b0;
    host_we_i  = 1'b0;
    last_latency = edges;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] unused;
    bus_access(1'b1, adr, dat, sel, unused);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
    bus_access(1'b0, adr, 32'h0, 4'hF, dat);
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic start_dma(input logic [31:0] src, input logic [31:0] dst, input int words);
    wb_write(dma_reg(periph_pkg::DMA_SRC_OFS), src, 4'hF);
    wb_write(dma_reg(periph_pkg::DMA_DST_OFS), dst, 4'hF);
    wb_write(dma_reg(periph_pkg::DMA_SIZE_OFS), 32'(words), 4'hF);
    wb_write(dma_reg(periph_pkg::DMA_CTRL_OFS), 32'h1, 4'hF);
  endtask

  // waits for done, compares the copy with the source words, then clears done
  task automatic finish_copy(input logic [31:0] dst);
    logic [31:0] d;
    while (!dma_done_o) @(negedge clk_i);
    for (int i = 0; i < COPY_WORDS; i++) begin
      wb_read(dst + 32'(i * 4), d);
      check_value($sformatf("mem[0x%h]", dst + 32'(i * 4)), src_words[i], d);
    end
    wb_write(dma_reg(periph_pkg::DMA_CTRL_OFS), 32'h2, 4'hF);
    check_value("dma_done_o", 32'h0, {31'h0, dma_done_o});
  endtask

  task automatic reset_state();
    int e;
    logic [31:0] d;
    e = errors;
    check_value("gpio_oe_o", 32'h0, {24'h0, gpio_oe_o});
    check_value("gpio_o", 32'h0, {24'h0, gpio_o});
    check_value("exit_valid_o", 32'h0, {31'h0, exit_valid_o});
    check_value("dma_done_o", 32'h0, {31'h0, dma_done_o});
    wb_read(ao_reg(periph_pkg::GPIO_OUT_OFS), d);
    check_value("GPIO_OUT", 32'h0, d);
    check_value("host_ack_o latency", 32'd2, 32'(last_latency));
    wb_read(dma_reg(periph_pkg::DMA_CTRL_OFS), d);
    check_value("DMA_CTRL", 32'h0, d);
    report_test("reset_state", e);
  endtask

  task automatic ram_access();
    int e;
    logic [31:0] adr [16];
    logic [31:0] dat [16];
    logic [31:0] d;
    e = errors;
    // one word in each 16-word slice keeps the addresses distinct
    for (int i = 0; i < 16; i++) begin
      adr[i] = 32'(i * 64) + ((next_random() & 32'hF) << 2);
      dat[i] = next_random();
      wb_write(adr[i], dat[i], 4'hF);
    end
    for (int i = 0; i < 16; i++) begin
      wb_read(adr[i], d);
      check_value($sformatf("mem[0x%h]", adr[i]), dat[i], d);
    end
    wb_write(32'h4B0, 32'hAABB_CCDD, 4'hF);
    wb_write(32'h4B0, 32'h1122_3344, 4'b0101);
    wb_read(32'h4B0, d);
    check_value("mem[0x4b0] byte write", 32'hAA22_CC44, d);
    report_test("ram_access", e);
  endtask

  task automatic gpio_and_exit();
    int e;
    logic [31:0] v;
    logic [31:0] d;
    e = errors;
    v = next_random() & 32'hFF;
    wb_write(ao_reg(periph_pkg::GPIO_OUT_OFS), v, 4'hF);
    check_value("gpio_o", v, {24'h0, gpio_o});
    v = next_random() & 32'hFF;
    wb_write(ao_reg(periph_pkg::GPIO_OE_OFS), v, 4'hF);
    check_value("gpio_oe_o", v, {24'h0, gpio_oe_o});
    v = next_random() & 32'hFF;
    gpio_i = v[7:0];
    repeat (3) @(negedge clk_i);
    wb_read(ao_reg(periph_pkg::GPIO_IN_OFS), d);
    check_value("GPIO_IN", v, d);
    v = next_random();
    wb_write(ao_reg(periph_pkg::EXIT_VALUE_OFS), v, 4'hF);
    wb_write(ao_reg(periph_pkg::EXIT_VALID_OFS), 32'h1, 4'hF);
    check_value("exit_valid_o", 32'h1, {31'h0, exit_valid_o});
    check_value("exit_value_o", v, exit_value_o);
    report_test("gpio_and_exit", e);
  endtask

  task automatic dma_copy();
    int e;
    logic [31:0] mark0;
    logic [31:0] mark1;
    logic [31:0] d;
    e = errors;
    for (int i = 0; i < COPY_WORDS; i++) begin
      src_words[i] = next_random();
      wb_write(SRC_BASE + 32'(i * 4), src_words[i], 4'hF);
    end
    mark0 = next_random();
    mark1 = next_random();
    wb_write(DST_BASE + 32'(COPY_WORDS * 4), mark0, 4'hF);
    wb_write(DST_BASE + 32'(COPY_WORDS * 4 + 4), mark1, 4'hF);
    start_dma(SRC_BASE, DST_BASE, COPY_WORDS);
    finish_copy(DST_BASE);
    wb_read(DST_BASE + 32'(COPY_WORDS * 4), d);
    check_value("word past copy end", mark0, d);
    wb_read(DST_BASE + 32'(COPY_WORDS * 4 + 4), d);
    check_value("second word past copy end", mark1, d);
    report_test("dma_copy", e);
  endtask

  task automatic bus_contention();
    int e;
    logic [31:0] dat [32];
    logic [31:0] d;
    e = errors;
    start_dma(SRC_BASE, DST2_BASE, COPY_WORDS);
    // host traffic interleaves with the running copy
    for (int i = 0; i < 32; i++) begin
      dat[i] = next_random();
      wb_write(HOST_BASE + 32'(i * 4), dat[i], 4'hF);
    end
    for (int i = 0; i < 32; i++) begin
      wb_read(HOST_BASE + 32'(i * 4), d);
      check_value($sformatf("mem[0x%h]", HOST_BASE + 32'(i * 4)), dat[i], d);
    end
    finish_copy(DST2_BASE);
    report_test("bus_contention", e);
  endtask

  task automatic unmapped_access();
    int e;
    logic [31:0] v;
    logic [31:0] d;
    e = errors;
    v = next_random();
    wb_write(32'h0, v, 4'hF);
    wb_write(UNMAPPED, ~v, 4'hF);
    wb_read(UNMAPPED, d);
    check_value("unmapped read data", 32'h0, d);
    wb_read(32'h0, d);
    check_value("mem[0x0]", v, d);
    report_test("unmapped_access", e);
  endtask

  initial begin
    rst_n_i    = 1'b0;
    host_cyc_i = 1'b0;
    host_stb_i = 1'b0;
    host_we_i  = 1'b0;
    host_adr_i = 32'h0;
    host_dat_i = 32'h0;
    host_sel_i = 4'h0;
    gpio_i     = 8'h0;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    reset_state();
    ram_access();
    gpio_and_exit();
    dma_copy();
    bus_contention();
    unmapped_access();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/mcu_pkg.sv
verilog/periph_pkg.sv
verilog/system_bus.sv
verilog/ram_bank.sv
verilog/dma_engine.sv
verilog/ao_peripheral.sv
verilog/core_v_mini_mcu.sv
verification/tb_core_v_mini_mcu.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f sim.f --top-module tb_core_v_mini_mcu > build.log 2>&1 \
  || { cat build.log; exit 1; }
./obj_dir/Vtb_core_v_mini_mcu > sim.log 2>&1 || echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0
